//--- source/tcm_bus_pkg.sv
// Bus widths and the address union shared by the TCM blocks
package tcm_bus_pkg;

    // ------------------------------------------------------------------------
    //  Widths
    // ------------------------------------------------------------------------
    localparam int unsigned DATA_W   = 32;
    localparam int unsigned ADDR_W   = 32;
    localparam int unsigned STRB_W   = DATA_W / 8;
    localparam int unsigned OFFSET_W = $clog2(STRB_W);
    localparam int unsigned INDEX_W  = 10;
    // Remaining upper bits pick the region
    localparam int unsigned TAG_W    = ADDR_W - INDEX_W - OFFSET_W;

    // ------------------------------------------------------------------------
    //  Address views
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic [TAG_W-1:0]    tag;
        logic [INDEX_W-1:0]  index;
        logic [OFFSET_W-1:0] offset;
    } tcm_addr_fields_t;

    // Same word seen as a byte address or as tag, word index and offset
    typedef union packed {
        logic [ADDR_W-1:0] flat;
        tcm_addr_fields_t  fields;
    } tcm_addr_u;

endpackage

//--- source/tcm_map_pkg.sv
// Address map of the ITCM and DTCM windows and the RAM geometry
package tcm_map_pkg;

    // ------------------------------------------------------------------------
    //  Windows
    // ------------------------------------------------------------------------
    localparam logic [tcm_bus_pkg::ADDR_W-1:0] ITCM_BASE = 32'h0000_0000;
    localparam logic [tcm_bus_pkg::ADDR_W-1:0] DTCM_BASE = 32'h0001_0000;

    // Bytes per window, identical for both RAMs
    localparam int unsigned TCM_SIZE  = 4096;

    // Words per RAM
    localparam int unsigned TCM_DEPTH = TCM_SIZE / tcm_bus_pkg::STRB_W;

    // ------------------------------------------------------------------------
    //  Region tags
    // ------------------------------------------------------------------------
    // Upper address bits of each base
    localparam logic [tcm_bus_pkg::TAG_W-1:0] ITCM_TAG =
        ITCM_BASE[tcm_bus_pkg::ADDR_W-1 -: tcm_bus_pkg::TAG_W];
    localparam logic [tcm_bus_pkg::TAG_W-1:0] DTCM_TAG =
        DTCM_BASE[tcm_bus_pkg::ADDR_W-1 -: tcm_bus_pkg::TAG_W];

endpackage

//--- source/tcm_ram.sv
// Word-wide single-port synchronous RAM with byte enables
`timescale 1ns/100ps

module tcm_ram #(
    parameter int unsigned DEPTH = 1024
) (
     input  logic                                clk_i
    ,input  logic                                en_i
    ,input  logic                                we_i
    ,input  logic [tcm_bus_pkg::STRB_W-1:0]      be_i
    ,input  logic [tcm_bus_pkg::INDEX_W-1:0]     index_i
    ,input  logic [tcm_bus_pkg::DATA_W-1:0]      wdata_i
    ,output logic [tcm_bus_pkg::DATA_W-1:0]      rdata_o
);

    // Storage array, behaves like a RAM macro
    logic [tcm_bus_pkg::DATA_W-1:0] mem [DEPTH];

    // ------------------------------------------------------------------------
    //  Write merge and registered read
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (en_i) begin
            if (we_i) begin
                for (int b = 0; b < tcm_bus_pkg::STRB_W; b++) begin
                    // Only strobed bytes change
                    if (be_i[b]) begin
                        mem[index_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                    end
                end
            end
            // Old contents on a write cycle
            rdata_o <= mem[index_i];
        end
    end

endmodule

//--- source/ext_access_decoder.sv
// External port decoder that steers to ITCM, DTCM or an error response
`timescale 1ns/100ps

module ext_access_decoder (
     input  logic                                clk_i
    ,input  logic                                arst_n_i
    // External request side
    ,input  logic                                ext_req_i
    ,input  tcm_bus_pkg::tcm_addr_u              ext_addr_i
    // Returns from the two arbiters
    ,input  logic                                itcm_ack_i
    ,input  logic [tcm_bus_pkg::DATA_W-1:0]      itcm_rdata_i
    ,input  logic                                dtcm_ack_i
    ,input  logic [tcm_bus_pkg::DATA_W-1:0]      dtcm_rdata_i
    // Steered requests
    ,output logic                                itcm_req_o
    ,output logic                                dtcm_req_o
    // Merged response
    ,output logic                                ext_ack_o
    ,output logic                                ext_error_o
    ,output logic [tcm_bus_pkg::DATA_W-1:0]      ext_rdata_o
);

    logic itcm_hit;
    logic dtcm_hit;
    logic addr_miss;
    logic err_ack_q;

    // ------------------------------------------------------------------------
    //  Window decode
    // ------------------------------------------------------------------------
    assign itcm_hit  = (ext_addr_i.fields.tag == tcm_map_pkg::ITCM_TAG);
    assign dtcm_hit  = (ext_addr_i.fields.tag == tcm_map_pkg::DTCM_TAG);
    assign addr_miss = !itcm_hit && !dtcm_hit;

    assign itcm_req_o = ext_req_i && itcm_hit;
    assign dtcm_req_o = ext_req_i && dtcm_hit;

    // ------------------------------------------------------------------------
    //  Error ack for addresses outside both windows
    // ------------------------------------------------------------------------
    // Request is still held in the ack cycle, so skip it there
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            err_ack_q <= 1'b0;
        end else begin
            err_ack_q <= ext_req_i && addr_miss && !err_ack_q;
        end
    end

    // ------------------------------------------------------------------------
    //  Response merge
    // ------------------------------------------------------------------------
    assign ext_ack_o   = itcm_ack_i || dtcm_ack_i || err_ack_q;
    assign ext_error_o = err_ack_q;

    always_comb begin
        if (itcm_ack_i) begin
            ext_rdata_o = itcm_rdata_i;
        end else if (dtcm_ack_i) begin
            ext_rdata_o = dtcm_rdata_i;
        end else begin
            ext_rdata_o = '0;
        end
    end

endmodule

//--- source/fetch_arbiter.sv
// ITCM arbiter between core instruction fetch and external access
`timescale 1ns/100ps

module fetch_arbiter (
     input  logic                                clk_i
    ,input  logic                                arst_n_i
    // Core fetch, read only
    ,input  logic                                fetch_req_i
    ,input  tcm_bus_pkg::tcm_addr_u              fetch_addr_i
    ,output logic                                fetch_ack_o
    ,output logic [tcm_bus_pkg::DATA_W-1:0]      fetch_rdata_o
    // External side, whole words
    ,input  logic                                ext_req_i
    ,input  logic                                ext_we_i
    ,input  tcm_bus_pkg::tcm_addr_u              ext_addr_i
    ,input  logic [tcm_bus_pkg::DATA_W-1:0]      ext_wdata_i
    ,output logic                                ext_ack_o
    ,output logic [tcm_bus_pkg::DATA_W-1:0]      ext_rdata_o
    // ITCM macro
    ,output logic                                ram_en_o
    ,output logic                                ram_we_o
    ,output logic [tcm_bus_pkg::STRB_W-1:0]      ram_be_o
    ,output logic [tcm_bus_pkg::INDEX_W-1:0]     ram_index_o
    ,output logic [tcm_bus_pkg::DATA_W-1:0]      ram_wdata_o
    ,input  logic [tcm_bus_pkg::DATA_W-1:0]      ram_rdata_i
);

    logic ext_gnt;
    logic fetch_busy_q;
    logic ext_busy_q;

    // ------------------------------------------------------------------------
    //  Grant
    // ------------------------------------------------------------------------
    // Fetch always wins, external waits for a free cycle with no ack pending
    assign ext_gnt = ext_req_i && !fetch_req_i && !ext_busy_q;

    assign ram_en_o    = fetch_req_i || ext_gnt;
    assign ram_we_o    = ext_gnt && ext_we_i;
    assign ram_be_o    = {tcm_bus_pkg::STRB_W{ext_gnt && ext_we_i}};
    assign ram_index_o = fetch_req_i ? fetch_addr_i.fields.index : ext_addr_i.fields.index;
    assign ram_wdata_o = ext_wdata_i;

    // ------------------------------------------------------------------------
    //  In-flight flags
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            fetch_busy_q <= 1'b0;
            ext_busy_q   <= 1'b0;
        end else begin
            fetch_busy_q <= fetch_req_i;
            ext_busy_q   <= ext_gnt;
        end
    end

    // Ack together with the RAM output
    assign fetch_ack_o   = fetch_busy_q;
    assign fetch_rdata_o = fetch_busy_q ? ram_rdata_i : '0;
    assign ext_ack_o     = ext_busy_q;
    assign ext_rdata_o   = ext_busy_q ? ram_rdata_i : '0;

endmodule

//--- source/data_arbiter.sv
// DTCM arbiter between core load/store and external access
`timescale 1ns/100ps

module data_arbiter (
     input  logic                                clk_i
    ,input  logic                                arst_n_i
    // Core load/store with byte strobes
    ,input  logic                                data_req_i
    ,input  logic                                data_we_i
    ,input  tcm_bus_pkg::tcm_addr_u              data_addr_i
    ,input  logic [tcm_bus_pkg::DATA_W-1:0]      data_wdata_i
    ,input  logic [tcm_bus_pkg::STRB_W-1:0]      data_strb_i
    ,output logic                                data_ack_o
    ,output logic [tcm_bus_pkg::DATA_W-1:0]      data_rdata_o
    // External side, whole words
    ,input  logic                                ext_req_i
    ,input  logic                                ext_we_i
    ,input  tcm_bus_pkg::tcm_addr_u              ext_addr_i
    ,input  logic [tcm_bus_pkg::DATA_W-1:0]      ext_wdata_i
    ,output logic                                ext_ack_o
    ,output logic [tcm_bus_pkg::DATA_W-1:0]      ext_rdata_o
    // DTCM macro
    ,output logic                                ram_en_o
    ,output logic                                ram_we_o
    ,output logic [tcm_bus_pkg::STRB_W-1:0]      ram_be_o
    ,output logic [tcm_bus_pkg::INDEX_W-1:0]     ram_index_o
    ,output logic [tcm_bus_pkg::DATA_W-1:0]      ram_wdata_o
    ,input  logic [tcm_bus_pkg::DATA_W-1:0]      ram_rdata_i
);

    logic ext_gnt;
    logic data_busy_q;
    logic ext_busy_q;

    // ------------------------------------------------------------------------
    //  Grant and RAM steering
    // ------------------------------------------------------------------------
    // Core has priority in the cycle it asks
    assign ext_gnt = ext_req_i && !data_req_i && !ext_busy_q;

    always_comb begin
        ram_en_o = data_req_i || ext_gnt;
        if (data_req_i) begin
            ram_we_o    = data_we_i;
            ram_be_o    = data_strb_i;
            ram_index_o = data_addr_i.fields.index;
            ram_wdata_o = data_wdata_i;
        end else begin
            // External writes cover the whole word
            ram_we_o    = ext_gnt && ext_we_i;
            ram_be_o    = '1;
            ram_index_o = ext_addr_i.fields.index;
            ram_wdata_o = ext_wdata_i;
        end
    end

    // ------------------------------------------------------------------------
    //  In-flight flags
    // ------------------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            data_busy_q <= 1'b0;
            ext_busy_q  <= 1'b0;
        end else begin
            data_busy_q <= data_req_i;
            ext_busy_q  <= ext_gnt;
        end
    end

    assign data_ack_o   = data_busy_q;
    assign data_rdata_o = data_busy_q ? ram_rdata_i : '0;
    assign ext_ack_o    = ext_busy_q;
    assign ext_rdata_o  = ext_busy_q ? ram_rdata_i : '0;

endmodule

//--- source/tcm_subsystem_top.sv
// TCM subsystem top with external decoder, two arbiters and two RAMs
`timescale 1ns/100ps

module tcm_subsystem_top (
     input  logic                                clk_i
    ,input  logic                                arst_n_i
    // Core instruction fetch
    ,input  logic                                fetch_req_i
    ,input  logic [tcm_bus_pkg::ADDR_W-1:0]      fetch_addr_i
    ,output logic                                fetch_ack_o
    ,output logic [tcm_bus_pkg::DATA_W-1:0]      fetch_rdata_o
    // Core load/store
    ,input  logic                                data_req_i
    ,input  logic                                data_we_i
    ,input  logic [tcm_bus_pkg::ADDR_W-1:0]      data_addr_i
    ,input  logic [tcm_bus_pkg::DATA_W-1:0]      data_wdata_i
    ,input  logic [tcm_bus_pkg::STRB_W-1:0]      data_strb_i
    ,output logic                                data_ack_o
    ,output logic [tcm_bus_pkg::DATA_W-1:0]      data_rdata_o
    // External access
    ,input  logic                                ext_req_i
    ,input  logic                                ext_we_i
    ,input  logic [tcm_bus_pkg::ADDR_W-1:0]      ext_addr_i
    ,input  logic [tcm_bus_pkg::DATA_W-1:0]      ext_wdata_i
    ,output logic                                ext_ack_o
    ,output logic                                ext_error_o
    ,output logic [tcm_bus_pkg::DATA_W-1:0]      ext_rdata_o
);

    logic                                itcm_ext_req;
    logic                                itcm_ext_ack;
    logic [tcm_bus_pkg::DATA_W-1:0]      itcm_ext_rdata;
    logic                                dtcm_ext_req;
    logic                                dtcm_ext_ack;
    logic [tcm_bus_pkg::DATA_W-1:0]      dtcm_ext_rdata;

    logic                                itcm_en;
    logic                                itcm_we;
    logic [tcm_bus_pkg::STRB_W-1:0]      itcm_be;
    logic [tcm_bus_pkg::INDEX_W-1:0]     itcm_index;
    logic [tcm_bus_pkg::DATA_W-1:0]      itcm_wdata;
    logic [tcm_bus_pkg::DATA_W-1:0]      itcm_rdata;

    logic                                dtcm_en;
    logic                                dtcm_we;
    logic [tcm_bus_pkg::STRB_W-1:0]      dtcm_be;
    logic [tcm_bus_pkg::INDEX_W-1:0]     dtcm_index;
    logic [tcm_bus_pkg::DATA_W-1:0]      dtcm_wdata;
    logic [tcm_bus_pkg::DATA_W-1:0]      dtcm_rdata;

    // ------------------------------------------------------------------------
    //  External access decode
    // ------------------------------------------------------------------------
    ext_access_decoder U_EXT_DECODER (
         .clk_i        ( clk_i          )
        ,.arst_n_i     ( arst_n_i       )
        ,.ext_req_i    ( ext_req_i      )
        ,.ext_addr_i   ( ext_addr_i     )
        ,.itcm_ack_i   ( itcm_ext_ack   )
        ,.itcm_rdata_i ( itcm_ext_rdata )
        ,.dtcm_ack_i   ( dtcm_ext_ack   )
        ,.dtcm_rdata_i ( dtcm_ext_rdata )
        ,.itcm_req_o   ( itcm_ext_req   )
        ,.dtcm_req_o   ( dtcm_ext_req   )
        ,.ext_ack_o    ( ext_ack_o      )
        ,.ext_error_o  ( ext_error_o    )
        ,.ext_rdata_o  ( ext_rdata_o    )
    );

    // ------------------------------------------------------------------------
    //  ITCM side
    // ------------------------------------------------------------------------
    fetch_arbiter U_FETCH_ARB (
         .clk_i         ( clk_i          )
        ,.arst_n_i      ( arst_n_i       )
        ,.fetch_req_i   ( fetch_req_i    )
        ,.fetch_addr_i  ( fetch_addr_i   )
        ,.fetch_ack_o   ( fetch_ack_o    )
        ,.fetch_rdata_o ( fetch_rdata_o  )
        ,.ext_req_i     ( itcm_ext_req   )
        ,.ext_we_i      ( ext_we_i       )
        ,.ext_addr_i    ( ext_addr_i     )
        ,.ext_wdata_i   ( ext_wdata_i    )
        ,.ext_ack_o     ( itcm_ext_ack   )
        ,.ext_rdata_o   ( itcm_ext_rdata )
        ,.ram_en_o      ( itcm_en        )
        ,.ram_we_o      ( itcm_we        )
        ,.ram_be_o      ( itcm_be        )
        ,.ram_index_o   ( itcm_index     )
        ,.ram_wdata_o   ( itcm_wdata     )
        ,.ram_rdata_i   ( itcm_rdata     )
    );

    tcm_ram #(
        .DEPTH ( tcm_map_pkg::TCM_DEPTH )
    ) U_ITCM (
         .clk_i   ( clk_i      )
        ,.en_i    ( itcm_en    )
        ,.we_i    ( itcm_we    )
        ,.be_i    ( itcm_be    )
        ,.index_i ( itcm_index )
        ,.wdata_i ( itcm_wdata )
        ,.rdata_o ( itcm_rdata )
    );

    // ------------------------------------------------------------------------
    //  DTCM side
    // ------------------------------------------------------------------------
    data_arbiter U_DATA_ARB (
         .clk_i        ( clk_i          )
        ,.arst_n_i     ( arst_n_i       )
        ,.data_req_i   ( data_req_i     )
        ,.data_we_i    ( data_we_i      )
        ,.data_addr_i  ( data_addr_i    )
        ,.data_wdata_i ( data_wdata_i   )
        ,.data_strb_i  ( data_strb_i    )
        ,.data_ack_o   ( data_ack_o     )
        ,.data_rdata_o ( data_rdata_o   )
        ,.ext_req_i    ( dtcm_ext_req   )
        ,.ext_we_i     ( ext_we_i       )
        ,.ext_addr_i   ( ext_addr_i     )
        ,.ext_wdata_i  ( ext_wdata_i    )
        ,.ext_ack_o    ( dtcm_ext_ack   )
        ,.ext_rdata_o  ( dtcm_ext_rdata )
        ,.ram_en_o     ( dtcm_en        )
        ,.ram_we_o     ( dtcm_we        )
        ,.ram_be_o     ( dtcm_be        )
        ,.ram_index_o  ( dtcm_index     )
        ,.ram_wdata_o  ( dtcm_wdata     )
        ,.ram_rdata_i  ( dtcm_rdata     )
    );

    tcm_ram #(
        .DEPTH ( tcm_map_pkg::TCM_DEPTH )
    ) U_DTCM (
         .clk_i   ( clk_i      )
        ,.en_i    ( dtcm_en    )
        ,.we_i    ( dtcm_we    )
        ,.be_i    ( dtcm_be    )
        ,.index_i ( dtcm_index )
        ,.wdata_i ( dtcm_wdata )
        ,.rdata_o ( dtcm_rdata )
    );

endmodule

//--- include/tb_vectors.svh
// Port codes, row type and stimulus table of the TCM subsystem testbench
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

    localparam logic [1:0] P_FETCH = 2'd0;
    localparam logic [1:0] P_DATA  = 2'd1;
    localparam logic [1:0] P_EXT   = 2'd2;
    // Core data access plus an external read of the same word
    localparam logic [1:0] P_BOTH  = 2'd3;

    typedef struct packed {
        logic [1:0]  port;
        logic        we;
        logic        rnd;
        logic [31:0] addr;
        logic [31:0] data;
        logic [3:0]  strb;
        logic        exp_err;
    } vec_row_t;

    localparam int NUM_ROWS = 27;

    vec_row_t vectors [NUM_ROWS];

    // Columns are port, write, random data, address, data, strobe and expected error
    task automatic load_vectors();
        // ITCM image loaded over the external port and fetched back to back
        vectors[0]  = '{P_EXT,   1'b1, 1'b0, 32'h0000_0000, 32'h0000_0013, 4'hf, 1'b0};
        vectors[1]  = '{P_EXT,   1'b1, 1'b1, 32'h0000_0004, 32'h0000_0000, 4'hf, 1'b0};
        vectors[2]  = '{P_EXT,   1'b1, 1'b0, 32'h0000_0008, 32'h00a0_0093, 4'hf, 1'b0};
        vectors[3]  = '{P_EXT,   1'b1, 1'b1, 32'h0000_0ffc, 32'h0000_0000, 4'hf, 1'b0};
        vectors[4]  = '{P_FETCH, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'h0, 1'b0};
        vectors[5]  = '{P_FETCH, 1'b0, 1'b0, 32'h0000_0004, 32'h0000_0000, 4'h0, 1'b0};
        vectors[6]  = '{P_FETCH, 1'b0, 1'b0, 32'h0000_0008, 32'h0000_0000, 4'h0, 1'b0};
        vectors[7]  = '{P_FETCH, 1'b0, 1'b0, 32'h0000_0ffc, 32'h0000_0000, 4'h0, 1'b0};
        // Core stores with partial strobes followed by loads
        vectors[8]  = '{P_DATA,  1'b1, 1'b0, 32'h0001_0020, 32'h1122_3344, 4'hf, 1'b0};
        vectors[9]  = '{P_DATA,  1'b1, 1'b0, 32'h0001_0020, 32'haabb_ccdd, 4'h5, 1'b0};
        vectors[10] = '{P_DATA,  1'b1, 1'b1, 32'h0001_0024, 32'h0000_0000, 4'hf, 1'b0};
        vectors[11] = '{P_DATA,  1'b1, 1'b0, 32'h0001_0024, 32'h0000_ee00, 4'h2, 1'b0};
        vectors[12] = '{P_DATA,  1'b0, 1'b0, 32'h0001_0020, 32'h0000_0000, 4'h0, 1'b0};
        vectors[13] = '{P_DATA,  1'b0, 1'b0, 32'h0001_0024, 32'h0000_0000, 4'h0, 1'b0};
        // Out-of-window core store aliases onto DTCM word 10
        vectors[14] = '{P_DATA,  1'b1, 1'b0, 32'h0000_0028, 32'hcafe_f00d, 4'hf, 1'b0};
        vectors[15] = '{P_DATA,  1'b0, 1'b0, 32'h0001_0028, 32'h0000_0000, 4'h0, 1'b0};
        // External reads of the DTCM and accesses outside both windows
        vectors[16] = '{P_EXT,   1'b0, 1'b0, 32'h0001_0020, 32'h0000_0000, 4'hf, 1'b0};
        vectors[17] = '{P_EXT,   1'b0, 1'b0, 32'h0001_0024, 32'h0000_0000, 4'hf, 1'b0};
        vectors[18] = '{P_EXT,   1'b1, 1'b0, 32'h0002_0020, 32'hdead_beef, 4'hf, 1'b1};
        vectors[19] = '{P_EXT,   1'b0, 1'b0, 32'h0003_0000, 32'h0000_0000, 4'hf, 1'b1};
        vectors[20] = '{P_EXT,   1'b0, 1'b0, 32'h0001_0020, 32'h0000_0000, 4'hf, 1'b0};
        vectors[21] = '{P_EXT,   1'b1, 1'b0, 32'h8000_0000, 32'h1234_5678, 4'hf, 1'b1};
        vectors[22] = '{P_FETCH, 1'b0, 1'b0, 32'h0000_0000, 32'h0000_0000, 4'h0, 1'b0};
        // Core and external port on the DTCM in the same cycle
        vectors[23] = '{P_BOTH,  1'b1, 1'b1, 32'h0001_0030, 32'h0000_0000, 4'hf, 1'b0};
        vectors[24] = '{P_BOTH,  1'b0, 1'b0, 32'h0001_0024, 32'h0000_0000, 4'h0, 1'b0};
        vectors[25] = '{P_DATA,  1'b0, 1'b0, 32'h0001_0030, 32'h0000_0000, 4'h0, 1'b0};
        // External read back of an ITCM word
        vectors[26] = '{P_EXT,   1'b0, 1'b0, 32'h0000_0ffc, 32'h0000_0000, 4'hf, 1'b0};
    endtask

`endif

//--- sim/tb_tcm_subsystem.sv
// Testbench for the TCM subsystem with a table-driven loop and RAM word models
`timescale 1ns/100ps

module tb_tcm_subsystem;

    localparam int TIMEOUT_CYCLES = 50;
    localparam int CORE_HOLD      = 3;

    logic        clk_i;
    logic        arst_n_i;
    logic        fetch_req_i;
    logic [31:0] fetch_addr_i;
    logic        fetch_ack_o;
    logic [31:0] fetch_rdata_o;
    logic        data_req_i;
    logic        data_we_i;
    logic [31:0] data_addr_i;
    logic [31:0] data_wdata_i;
    logic [3:0]  data_strb_i;
    logic        data_ack_o;
    logic [31:0] data_rdata_o;
    logic        ext_req_i;
    logic        ext_we_i;
    logic [31:0] ext_addr_i;
    logic [31:0] ext_wdata_i;
    logic        ext_ack_o;
    logic        ext_error_o;
    logic [31:0] ext_rdata_o;

    `include "tb_vectors.svh"

    // Word models of both RAMs
    logic [31:0] itcm_model [1024];
    logic [31:0] dtcm_model [1024];

    // Core strobe driven last cycle and acked in this one
    logic        pend_valid;
    logic        pend_fetch;
    logic        pend_read;
    logic [31:0] pend_exp;
    int          pend_row;

    int          err_count;
    int          rows_done;
    int          rows_failed;
    logic        timed_out;

    tcm_subsystem_top UUT (.*);

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Returns 0 for the ITCM, 1 for the DTCM and 2 outside both windows
    function automatic int window_of(input logic [31:0] addr);
        if (addr[31:12] == 20'h00000) begin
            return 0;
        end else if (addr[31:12] == 20'h00010) begin
            return 1;
        end
        return 2;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  strb);
        logic [31:0] result;
        int          b;
        result = old_word;
        for (b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = new_word[b*8 +: 8];
            end
        end
        return result;
    endfunction

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic report_mismatch(input string sig, input logic [31:0] exp,
                                   input logic [31:0] act);
        $display("[ERROR] %0t %s expected 0x%08h actual 0x%08h", $time, sig, exp, act);
        err_count++;
    endtask

    task automatic finish_row(input int idx, input int errs_before);
        rows_done++;
        if (err_count == errs_before) begin
            $display("row %0d ok", idx);
        end else begin
            $display("row %0d FAILED", idx);
            rows_failed++;
        end
    endtask

    task automatic idle_core();
        fetch_req_i = 1'b0;
        data_req_i  = 1'b0;
        data_we_i   = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    //  Core ports with one strobe per cycle
    // ------------------------------------------------------------------------
    task automatic retire_core();
        int errs_before;
        errs_before = err_count;
        if (fetch_ack_o !== (pend_valid && pend_fetch)) begin
            report_mismatch("fetch_ack_o", 32'(pend_valid && pend_fetch), 32'(fetch_ack_o));
        end
        if (data_ack_o !== (pend_valid && !pend_fetch)) begin
            report_mismatch("data_ack_o", 32'(pend_valid && !pend_fetch), 32'(data_ack_o));
        end
        if (pend_valid && pend_read && pend_fetch && fetch_rdata_o !== pend_exp) begin
            report_mismatch("fetch_rdata_o", pend_exp, fetch_rdata_o);
        end
        if (pend_valid && pend_read && !pend_fetch && data_rdata_o !== pend_exp) begin
            report_mismatch("data_rdata_o", pend_exp, data_rdata_o);
        end
        if (pend_valid) begin
            finish_row(pend_row, errs_before);
        end
        pend_valid = 1'b0;
    endtask

    task automatic issue_core(input int idx, input vec_row_t row);
        int windex;
        windex       = int'(row.addr[11:2]);
        fetch_req_i  = (row.port == P_FETCH);
        fetch_addr_i = row.addr;
        data_req_i   = (row.port != P_FETCH);
        data_we_i    = row.we;
        data_addr_i  = row.addr;
        data_wdata_i = row.data;
        data_strb_i  = row.strb;
        pend_valid   = 1'b1;
        pend_fetch   = (row.port == P_FETCH);
        pend_read    = !row.we;
        pend_row     = idx;
        if (row.port == P_FETCH) begin
            pend_exp = itcm_model[windex];
        end else begin
            pend_exp = dtcm_model[windex];
            if (row.we) begin
                dtcm_model[windex] = merge_bytes(dtcm_model[windex], row.data, row.strb);
            end
        end
    endtask

    // ------------------------------------------------------------------------
    //  External port with the request held until ack
    // ------------------------------------------------------------------------
    task automatic wait_ext_ack(input int idx);
        int waited;
        waited = 0;
        do begin
            next_cycle();
            waited++;
        end while (!ext_ack_o && waited < TIMEOUT_CYCLES);
        if (!ext_ack_o) begin
            $display("Timeout: row %0d saw no ext_ack_o within %0d cycles", idx, TIMEOUT_CYCLES);
            timed_out = 1'b1;
        end
    endtask

    // Request stays up through the ack cycle and is served only once
    task automatic hold_through_ack();
        next_cycle();
        if (ext_ack_o !== 1'b0) begin
            report_mismatch("ext_ack_o", 32'd0, 32'(ext_ack_o));
        end
    endtask

    task automatic ext_access(input int idx, input vec_row_t row);
        int          errs_before;
        int          windex;
        int          win;
        logic [31:0] exp_rd;
        errs_before = err_count;
        windex      = int'(row.addr[11:2]);
        win         = window_of(row.addr);
        exp_rd      = (win == 0) ? itcm_model[windex] : dtcm_model[windex];
        ext_req_i   = 1'b1;
        ext_we_i    = row.we;
        ext_addr_i  = row.addr;
        ext_wdata_i = row.data;
        wait_ext_ack(idx);
        if (!timed_out) begin
            if (ext_error_o !== row.exp_err) begin
                report_mismatch("ext_error_o", 32'(row.exp_err), 32'(ext_error_o));
            end
            if (!row.we && win != 2 && ext_rdata_o !== exp_rd) begin
                report_mismatch("ext_rdata_o", exp_rd, ext_rdata_o);
            end
            hold_through_ack();
            if (row.we && win == 0) begin
                itcm_model[windex] = row.data;
            end
            if (row.we && win == 1) begin
                dtcm_model[windex] = row.data;
            end
            finish_row(idx, errs_before);
        end
        ext_req_i = 1'b0;
        ext_we_i  = 1'b0;
    endtask

    // Core holds the DTCM for a few cycles while the external read waits
    task automatic contend_dtcm(input int idx, input vec_row_t row);
        int          errs_before;
        int          windex;
        int          k;
        logic [31:0] exp_core;
        logic [31:0] exp_ext;
        errs_before = err_count;
        windex      = int'(row.addr[11:2]);
        exp_core    = dtcm_model[windex];
        if (row.we) begin
            dtcm_model[windex] = merge_bytes(dtcm_model[windex], row.data, row.strb);
        end
        exp_ext      = dtcm_model[windex];
        data_req_i   = 1'b1;
        data_we_i    = row.we;
        data_addr_i  = row.addr;
        data_wdata_i = row.data;
        data_strb_i  = row.strb;
        ext_req_i    = 1'b1;
        ext_we_i     = 1'b0;
        ext_addr_i   = row.addr;
        ext_wdata_i  = '0;
        for (k = 0; k < CORE_HOLD; k++) begin
            next_cycle();
            if (data_ack_o !== 1'b1) begin
                report_mismatch("data_ack_o", 32'd1, 32'(data_ack_o));
            end
            if (!row.we && data_rdata_o !== exp_core) begin
                report_mismatch("data_rdata_o", exp_core, data_rdata_o);
            end
            if (ext_ack_o !== 1'b0) begin
                report_mismatch("ext_ack_o", 32'd0, 32'(ext_ack_o));
            end
        end
        data_req_i = 1'b0;
        wait_ext_ack(idx);
        if (!timed_out) begin
            if (ext_error_o !== 1'b0) begin
                report_mismatch("ext_error_o", 32'd0, 32'(ext_error_o));
            end
            if (ext_rdata_o !== exp_ext) begin
                report_mismatch("ext_rdata_o", exp_ext, ext_rdata_o);
            end
            hold_through_ack();
            finish_row(idx, errs_before);
        end
        ext_req_i = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    //  Main sequence
    // ------------------------------------------------------------------------
    initial begin
        vec_row_t row;
        int       i;
        void'($urandom(32'h16e8));
        err_count    = 0;
        rows_done    = 0;
        rows_failed  = 0;
        timed_out    = 1'b0;
        pend_valid   = 1'b0;
        pend_fetch   = 1'b0;
        pend_read    = 1'b0;
        pend_exp     = '0;
        pend_row     = 0;
        arst_n_i     = 1'b0;
        fetch_req_i  = 1'b0;
        fetch_addr_i = '0;
        data_req_i   = 1'b0;
        data_we_i    = 1'b0;
        data_addr_i  = '0;
        data_wdata_i = '0;
        data_strb_i  = '0;
        ext_req_i    = 1'b0;
        ext_we_i     = 1'b0;
        ext_addr_i   = '0;
        ext_wdata_i  = '0;
        load_vectors();
        repeat (2) @(posedge clk_i);
        #1;
        if (fetch_ack_o || data_ack_o || ext_ack_o || ext_error_o) begin
            $display("Acks or error not low during reset");
            err_count++;
        end
        arst_n_i = 1'b1;
        for (i = 0; i < NUM_ROWS; i++) begin
            row = vectors[i];
            if (row.rnd) begin
                row.data = $urandom;
            end
            next_cycle();
            retire_core();
            if (row.port == P_EXT) begin
                idle_core();
                ext_access(i, row);
            end else if (row.port == P_BOTH) begin
                idle_core();
                contend_dtcm(i, row);
            end else begin
                issue_core(i, row);
            end
            if (timed_out) begin
                break;
            end
        end
        if (!timed_out) begin
            next_cycle();
            retire_core();
            idle_core();
        end
        $display("rows %0d done, %0d failed, %0d errors", rows_done, rows_failed, err_count);
        if (err_count == 0 && !timed_out) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

//--- vlog.f
+incdir+include
source/tcm_bus_pkg.sv
source/tcm_map_pkg.sv
source/tcm_ram.sv
source/ext_access_decoder.sv
source/fetch_arbiter.sv
source/data_arbiter.sv
source/tcm_subsystem_top.sv
sim/tb_tcm_subsystem.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the TCM subsystem testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    --top-module tb_tcm_subsystem -f vlog.f -o sim_tcm

sim_out=$(./obj_dir/sim_tcm)
echo "${sim_out}"

if grep -qx "Verification passed" <<< "${sim_out}"; then
    exit 0
fi
exit 1
